/* src.f */
+incdir+common
common/opl_pkg.sv
hw/opl_csr/opl_sh_rst.sv
hw/opl_csr/opl_csr.sv
hw/opl_write_port.sv
hw/opl_op_regs_top.sv
verif/opl_checker.sv
verif/opl_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module opl_tb -f src.f
	@out="$$(./obj_dir/Vopl_tb)"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

/* verif/opl_tb.sv */
// Directed testbench for the OPL operator register store with a reference model
`timescale 1ns/1ps
`include "opl_cfg.svh"

module opl_tb;

    localparam int          clk_half   = 10;
    localparam int          drive_dly  = 2;
    localparam int          reset_cyc  = 16;
    // Well above one rotation of about 27 clocks
    localparam int          wait_limit = 400;
    localparam logic [31:0] lcg_seed   = 32'h3a23_2c51;

    logic              clk;
    logic              cen;
    logic              reset;
    logic              wr;
    opl_pkg::wr_req_t  req;
    logic              busy;
    logic [4:0]        slot;
    opl_pkg::op_regs_t regs;

    // Expected word of every slot
    opl_pkg::op_regs_t model [`OPL_SLOTS];

    // Separate streams for cen stalls and write data
    logic [31:0]       cen_state;
    logic [31:0]       data_state;
    int                phase;

    opl_op_regs_top dut_i (
        .clk   (clk),
        .cen   (cen),
        .reset (reset),
        .wr    (wr),
        .req   (req),
        .busy  (busy),
        .slot  (slot),
        .regs  (regs)
    );

    bind opl_write_port opl_checker chk_i (
        .clk        (clk),
        .reset      (reset),
        .cen        (cen),
        .slot       (slot),
        .up         (up),
        .slot_match (slot_match)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #clk_half clk = ~clk;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Two cycles of three enabled plus rare extra stalls
    initial begin
        cen_state = lcg_seed;
        phase     = 0;
        cen       = 1'b0;
        forever begin
            @(posedge clk);
            #drive_dly;
            cen_state = lcg_next(cen_state);
            cen       = (phase != 2) && (cen_state[31:28] != 4'h0);
            phase     = (phase == 2) ? 0 : phase + 1;
        end
    end

    // Host offset to slot or -1 for a hole
    function automatic int offset_slot(input int offset);
        if (offset >= 0 && offset <= 5) begin
            return offset;
        end else if (offset >= 8 && offset <= 13) begin
            return offset - 2;
        end else if (offset >= 16 && offset <= 21) begin
            return offset - 4;
        end
        return -1;
    endfunction

    // Group 1 owns the top byte and group 4 the bottom one
    function automatic void apply_model(input int grp, input int s, input logic [7:0] data);
        logic [31:0] w;
        w = model[s];
        w[39 - 8 * grp -: 8] = data;
        model[s] = w;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
            abort_run("Mismatch between DUT and expected value");
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #drive_dly;
    endtask

    task automatic wait_busy_low;
        int n;
        n = 0;
        while (busy) begin
            if (n == wait_limit) begin
                abort_run("Timeout while waiting for busy to fall");
            end else begin
                next_cycle();
                n++;
            end
        end
    endtask

    task automatic wait_slot(input logic [4:0] s);
        int n;
        n = 0;
        while (slot != s) begin
            if (n == wait_limit) begin
                abort_run($sformatf("Timeout while waiting for slot %0d", s));
            end else begin
                next_cycle();
                n++;
            end
        end
    endtask

    // Wait for the counter to leave prev
    task automatic wait_advance(input logic [4:0] prev);
        int n;
        n = 0;
        while (slot == prev) begin
            if (n == wait_limit) begin
                abort_run($sformatf("Timeout, slot counter stuck at %0d", prev));
            end else begin
                next_cycle();
                n++;
            end
        end
    endtask

    // One-cycle write strobe
    task automatic drive_wr(input int grp, input int offset, input logic [7:0] data);
        wr       = 1'b1;
        req.addr = {grp[2:0], offset[4:0]};
        req.data = data;
        next_cycle();
        wr       = 1'b0;
    endtask

    task automatic write_reg(input int grp, input int offset, input logic [7:0] data);
        int   s;
        logic valid;
        s     = offset_slot(offset);
        valid = (grp >= 1) && (grp <= 4) && (s >= 0);
        wait_busy_low();
        drive_wr(grp, offset, data);
        if (valid) begin
            apply_model(grp, s, data);
            check_val("busy", 32'(busy), 32'd1);
            wait_busy_low();
        end else begin
            // Rejected writes never raise busy
            check_val("busy", 32'(busy), 32'd0);
        end
    endtask

    task automatic check_slot(input int s);
        wait_slot(5'(s));
        check_val($sformatf("regs[slot %0d]", s), regs, model[s]);
    endtask

    task automatic check_rotation;
        for (int s = 0; s < `OPL_SLOTS; s++) begin
            check_slot(s);
        end
    endtask

    task automatic test_reset;
        check_val("busy", 32'(busy), 32'd0);
        wait_slot(5'd0);
        check_val("regs", regs, 32'd0);
        // Slots must come up in order
        for (int s = 1; s < `OPL_SLOTS; s++) begin
            wait_advance(5'(s - 1));
            check_val("slot", 32'(slot), 32'(s));
            check_val("regs", regs, 32'd0);
        end
    endtask

    // Offset 9 is slot 7 and each group lands in its own byte
    task automatic test_groups;
        logic [7:0] data [4];
        data[0] = 8'ha5;
        data[1] = 8'h3c;
        data[2] = 8'hd2;
        data[3] = 8'h6b;
        for (int g = 1; g <= 4; g++) begin
            write_reg(g, 9, data[g-1]);
            check_slot(7);
            check_slot(8);
        end
    endtask

    // Holes at 6, 7, 14 and 15 fall between the banks
    task automatic test_all_offsets;
        int         grp;
        logic [7:0] data;
        for (int offset = 0; offset < 22; offset++) begin
            data_state = lcg_next(data_state);
            grp        = int'(data_state[9:8]) + 1;
            data       = data_state[7:0];
            write_reg(grp, offset, data);
        end
        check_rotation();
    endtask

    task automatic test_invalid;
        write_reg(2, 6, 8'hff);
        write_reg(2, 7, 8'hff);
        write_reg(2, 22, 8'hff);
        // Group codes outside 1 to 4
        write_reg(0, 3, 8'hff);
        write_reg(5, 3, 8'hff);
        write_reg(7, 3, 8'hff);
        check_rotation();
    endtask

    // Second write to offset 17 (slot 13) lands while busy
    task automatic test_drop;
        wait_busy_low();
        drive_wr(3, 17, 8'h5a);
        apply_model(3, 13, 8'h5a);
        check_val("busy", 32'(busy), 32'd1);
        drive_wr(3, 17, 8'hc3);
        wait_busy_low();
        next_cycle();
        check_val("busy", 32'(busy), 32'd0);
        check_slot(13);
        check_rotation();
    endtask

    initial begin
        reset      = 1'b1;
        wr         = 1'b0;
        req        = '0;
        data_state = lcg_seed;
        for (int i = 0; i < `OPL_SLOTS; i++) begin
            model[i] = '0;
        end
        repeat (reset_cyc) @(posedge clk);
        #drive_dly;
        reset = 1'b0;

        test_reset();
        test_groups();
        test_all_offsets();
        test_invalid();
        test_drop();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* verif/opl_checker.sv */
// Concurrent assertions on the OPL write port update strobes and slot counter
`timescale 1ns/1ps
`include "opl_cfg.svh"

module opl_checker (
    input logic             clk,
    input logic             reset,
    input logic             cen,
    input logic [4:0]       slot,
    input opl_pkg::reg_up_t up,
    input logic             slot_match
);

    // Strobes stay quiet outside the matching cycle
    property up_needs_match;
        @(posedge clk) disable iff (reset)
            !slot_match |-> (up == '0);
    endproperty

    // Never more than one field group per update
    property up_one_hot;
        @(posedge clk) disable iff (reset)
            $onehot0(up);
    endproperty

    // Counter wraps at the last slot
    property slot_in_range;
        @(posedge clk) disable iff (reset)
            slot <= 5'(`OPL_SLOTS - 1);
    endproperty

    // Counter holds on a stalled cycle
    property slot_holds_without_cen;
        @(posedge clk) disable iff (reset)
            !cen |=> $stable(slot);
    endproperty

    assert property (up_needs_match)
        else $error("update strobe set without a slot match");
    assert property (up_one_hot)
        else $error("more than one update strobe set");
    assert property (slot_in_range)
        else $error("slot counter out of range");
    assert property (slot_holds_without_cen)
        else $error("slot counter moved without cen");

endmodule

/* hw/opl_op_regs_top.sv */
// OPL operator register store top joining the host write port and the register ring
`timescale 1ns/1ps

module opl_op_regs_top (
    input  logic              clk,
    input  logic              cen,
    input  logic              reset,
    input  logic              wr,
    input  opl_pkg::wr_req_t  req,
    output logic              busy,
    output logic [4:0]        slot,
    output opl_pkg::op_regs_t regs
);

    // Update path from the write port into the ring
    opl_pkg::reg_up_t up;
    logic             slot_match;
    logic [7:0]       din;

    // Decode and slot timing
    opl_write_port u_write_port (
        .clk        (clk),
        .cen        (cen),
        .reset      (reset),
        .wr         (wr),
        .req        (req),
        .busy       (busy),
        .slot       (slot),
        .up         (up),
        .slot_match (slot_match),
        .din        (din)
    );

    // Ring tail is the word of the current slot
    opl_csr u_csr (
        .clk        (clk),
        .cen        (cen),
        .reset      (reset),
        .din        (din),
        .up         (up),
        .slot_match (slot_match),
        .shift_out  (regs)
    );

endmodule

/* hw/opl_write_port.sv */
// OPL host write port with address decode, slot counter and slot-matched update strobes
`timescale 1ns/1ps
`include "opl_cfg.svh"

module opl_write_port (
    input  logic             clk,
    input  logic             cen,
    input  logic             reset,
    input  logic             wr,
    input  opl_pkg::wr_req_t req,
    output logic             busy,
    output logic [4:0]       slot,
    output opl_pkg::reg_up_t up,
    output logic             slot_match,
    output logic [7:0]       din
);

    // Address fields
    logic [2:0]        grp;
    logic [4:0]        offset;

    // Decode results
    logic              grp_valid;
    logic              slot_valid;
    logic              addr_valid;
    logic [4:0]        slot_base;
    logic [4:0]        dec_slot;
    opl_pkg::reg_up_t  dec_up;

    // Control
    logic              accept;
    logic              hit;
    logic [4:0]        cnt;

    // Pending write
    opl_pkg::reg_up_t  pend_up;
    logic [4:0]        pend_slot;
    logic [7:0]        pend_data;

    assign grp    = req.addr[7:5];
    assign offset = req.addr[4:0];

    // Group code to field strobe
    always_comb begin
        dec_up    = '0;
        grp_valid = 1'b1;
        case (grp)
            `OPL_GRP_MULT:   dec_up.up_mult   = 1'b1;
            `OPL_GRP_KSL_TL: dec_up.up_ksl_tl = 1'b1;
            `OPL_GRP_AR_DR:  dec_up.up_ar_dr  = 1'b1;
            `OPL_GRP_SL_RR:  dec_up.up_sl_rr  = 1'b1;
            default:         grp_valid        = 1'b0;
        endcase
    end

    // Offsets come in three banks of six, eight apart
    always_comb begin
        case (offset[4:3])
            2'd0:    slot_base = 5'd0;
            2'd1:    slot_base = 5'd6;
            default: slot_base = 5'd12;
        endcase
    end

    // Bank 3 and offsets 6 and 7 within a bank are holes
    assign slot_valid = (offset[2:0] <= 3'd5) && (offset[4:3] != 2'd3);
    assign dec_slot   = slot_base + {2'b00, offset[2:0]};
    assign addr_valid = grp_valid && slot_valid;

    // Only one write in flight
    assign accept = wr && !busy && addr_valid;

    // Pending slot reached on an enabled cycle
    assign hit = busy && cen && (cnt == pend_slot);

    // Slot counter wraps after the last slot
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= 5'd0;
        end else if (cen) begin
            if (cnt == 5'(`OPL_SLOTS - 1)) begin
                cnt <= 5'd0;
            end else begin
                cnt <= cnt + 5'd1;
            end
        end
    end

    // Busy rises after capture
    // Falls on the edge that applies the update
    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            pend_up <= '0;
        end else if (accept) begin
            busy    <= 1'b1;
            pend_up <= dec_up;
        end else if (hit) begin
            busy    <= 1'b0;
            pend_up <= '0;
        end
    end

    // Target slot and data byte
    always_ff @(posedge clk) begin
        if (accept) begin
            pend_slot <= dec_slot;
            pend_data <= req.data;
        end
    end

    assign slot       = cnt;
    assign slot_match = hit;
    // Strobe only in the matching cycle
    assign up         = hit ? pend_up : '0;
    assign din        = pend_data;

endmodule

/* hw/opl_csr/opl_csr.sv */
// Circular operator register store with byte merge into the selected field group
`timescale 1ns/1ps
`include "opl_cfg.svh"

module opl_csr (
    input  logic              clk,
    input  logic              cen,
    input  logic              reset,
    input  logic [7:0]        din,
    input  opl_pkg::reg_up_t  up,
    input  logic              slot_match,
    output opl_pkg::op_regs_t shift_out
);

    // Next word entering the ring head
    opl_pkg::op_regs_t      regop_in;
    logic [`OPL_REG_W-1:0]  ring_in;
    logic [`OPL_REG_W-1:0]  ring_out;

    // Group strobes qualified by the slot match
    logic                   up_mult_op;
    logic                   up_ksl_tl_op;
    logic                   up_ar_dr_op;
    logic                   up_sl_rr_op;

    assign up_mult_op   = up.up_mult   & slot_match;
    assign up_ksl_tl_op = up.up_ksl_tl & slot_match;
    assign up_ar_dr_op  = up.up_ar_dr  & slot_match;
    assign up_sl_rr_op  = up.up_sl_rr  & slot_match;

    // Read-modify-write of the word leaving the ring
    always_comb begin
        // Recirculate by default
        regop_in = shift_out;
        // AM, VIB, EGT, KSR and MULT
        if (up_mult_op) begin
            regop_in.am   = din[7];
            regop_in.vib  = din[6];
            regop_in.egt  = din[5];
            regop_in.ksr  = din[4];
            regop_in.mult = din[3:0];
        end
        // Key scale level and total level
        if (up_ksl_tl_op) begin
            regop_in.ksl = din[7:6];
            regop_in.tl  = din[5:0];
        end
        // Attack and decay rates
        if (up_ar_dr_op) begin
            regop_in.ar = din[7:4];
            regop_in.dr = din[3:0];
        end
        // Sustain level and release rate
        if (up_sl_rr_op) begin
            regop_in.sl = din[7:4];
            regop_in.rr = din[3:0];
        end
    end

    assign ring_in = regop_in;

    // One stage per slot so the tail always holds the current slot
    opl_sh_rst #(
        .width  (`OPL_REG_W),
        .stages (`OPL_SLOTS)
    ) u_ring (
        .clk   (clk),
        .cen   (cen),
        .reset (reset),
        .din   (ring_in),
        .drop  (ring_out)
    );

    assign shift_out = ring_out;

endmodule

/* hw/opl_csr/opl_sh_rst.sv */
// Resettable multi-stage shift register advanced by the clock enable
`timescale 1ns/1ps

module opl_sh_rst #(
    parameter int width  = 32,
    parameter int stages = 18
) (
    input  logic             clk,
    input  logic             cen,
    input  logic             reset,
    input  logic [width-1:0] din,
    output logic [width-1:0] drop
);

    // Stage 0 is the head, the last stage feeds drop
    logic [width-1:0] bits [stages];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < stages; i++) begin
                bits[i] <= '0;
            end
        end else if (cen) begin
            bits[0] <= din;
            // Move every stage one step toward the tail
            for (int i = 1; i < stages; i++) begin
                bits[i] <= bits[i-1];
            end
        end
    end

    assign drop = bits[stages-1];

endmodule

/* common/opl_pkg.sv */
// OPL operator register types shared by the write port and the register store
package opl_pkg;

    // One operator register word, 32 bits
    // Field order follows the host byte layout, MSB first
    typedef struct packed {
        // Group 1 byte
        logic       am;
        logic       vib;
        logic       egt;
        logic       ksr;
        logic [3:0] mult;
        // Group 2 byte
        logic [1:0] ksl;
        logic [5:0] tl;
        // Group 3 byte
        logic [3:0] ar;
        logic [3:0] dr;
        // Group 4 byte
        logic [3:0] sl;
        logic [3:0] rr;
    } op_regs_t;

    // Field group update strobes
    // At most one is set per update
    typedef struct packed {
        logic up_mult;
        logic up_ksl_tl;
        logic up_ar_dr;
        logic up_sl_rr;
    } reg_up_t;

    // Host write request
    // addr[7:5] selects the group, addr[4:0] the operator offset
    typedef struct packed {
        logic [7:0] addr;
        logic [7:0] data;
    } wr_req_t;

endpackage

/* common/opl_cfg.svh */
// OPL operator register store configuration with slot count, word width and group codes
`ifndef OPL_CFG_SVH
`define OPL_CFG_SVH

// Operator slots in the ring, also the shift register depth
`define OPL_SLOTS 18

// Width of one operator register word
`define OPL_REG_W 32

// addr[7:5] values for each register group
`define OPL_GRP_MULT   3'd1
`define OPL_GRP_KSL_TL 3'd2
`define OPL_GRP_AR_DR  3'd3
`define OPL_GRP_SL_RR  3'd4

`endif
